//--- cpu_id_ex_top.f
+incdir+.
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/simd_byte_lane.sv
verilog/decode_stage.sv
verilog/id_ex_reg.sv
verilog/exec_stage.sv
verilog/cpu_id_ex_top.sv
dv/cpu_id_ex_tb.sv

//--- dv/cpu_id_ex_tb.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_id_ex_tb import isa_pkg::*, pipe_pkg::*;;

   // about 200 cycles of directed tests
   localparam int TEST_CYCLES    = 200;
   localparam int TIMEOUT_CYCLES = 10 * TEST_CYCLES;

   logic             clk;
   logic             rst_n;
   logic [`ILEN-1:0] instr;
   logic             instr_valid;
   logic             stall;
   logic             flush;
   wb_t              wb;

   logic [`XLEN-1:0] model_regs [`NUM_REGS];
   wb_t              ex_exp;
   wb_t              wb_exp;
   logic [`ILEN-1:0] prev_instr;
   logic             prev_valid;
   logic             prev_flush;
   logic             prev_stall;
   logic             halt_seen;
   integer           seed;
   int               mismatch_count;
   int               fail_count;
   int               cycle_count;

   cpu_id_ex_top cpu_id_ex_top_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .stall       (stall),
      .flush       (flush),
      .wb          (wb)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [`ILEN-1:0] r_type(input opcode_e op, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
      return {op, rd, rs, rt, 11'b0};
   endfunction

   function automatic logic [`ILEN-1:0] i_type(input opcode_e op, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [15:0] imm);
      return {op, rd, rs, imm};
   endfunction

   // per-byte packed ops
   function automatic logic [`XLEN-1:0] simd_model(input opcode_e op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
      logic [`XLEN-1:0] y;
      logic [7:0]       x;
      logic [7:0]       z;
      int               s;
      for (int j = 0; j < `NUM_LANES; j++) begin
         x = a[8*j +: 8];
         z = b[8*j +: 8];
         s = int'(x) + int'(z);
         case (op)
            PADDB:   y[8*j +: 8] = x + z;
            PSUBB:   y[8*j +: 8] = x - z;
            PADDUSB: y[8*j +: 8] = (s > 255) ? 8'hff : 8'(s);
            default: y[8*j +: 8] = (x > z) ? x : z;
         endcase
      end
      return y;
   endfunction

   // in-order reference that retires into model_regs at decode time
   function automatic wb_t predict(input logic [`ILEN-1:0] ins, input logic v, input logic f);
      wb_t              r;
      opcode_e          op;
      logic [`XLEN-1:0] a;
      logic [`XLEN-1:0] b;
      logic [`XLEN-1:0] imm;
      r = '0;
      if (f || !v) begin
         return r;
      end
      op      = opcode_e'(ins[31:26]);
      a       = model_regs[ins[20:16]];
      b       = model_regs[ins[15:11]];
      imm     = {{16{ins[15]}}, ins[15:0]};
      r.valid = 1'b1;
      r.rd    = ins[25:21];
      r.wr_en = 1'b1;
      case (op)
         LI:     r.data = imm;
         ADD:    r.data = a + b;
         SUB:    r.data = a - b;
         AND_OP: r.data = a & b;
         OR_OP:  r.data = a | b;
         XOR_OP: r.data = a ^ b;
         SLT:    r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         ADDI:   r.data = a + imm;
         PADDB, PSUBB, PADDUSB, PMAXUB: r.data = simd_model(op, a, b);
         HALT: begin
            r.wr_en = 1'b0;
            r.halt  = 1'b1;
         end
         default: r.wr_en = 1'b0;
      endcase
      if (r.wr_en && r.rd != '0) begin
         model_regs[r.rd] = r.data;
      end
      return r;
   endfunction

   task automatic check_wb(input string name, input wb_t exp, input wb_t act);
      if (act.valid !== exp.valid || act.wr_en !== exp.wr_en ||
          (exp.wr_en && (act.rd !== exp.rd || act.data !== exp.data))) begin
         mismatch_count++;
         $display("MISMATCH %s: expected valid=%0b wr_en=%0b rd=%0d data=%h", name,
                  exp.valid, exp.wr_en, exp.rd, exp.data);
         $display("MISMATCH %s: actual   valid=%0b wr_en=%0b rd=%0d data=%h", name,
                  act.valid, act.wr_en, act.rd, act.data);
      end
   endtask

   task automatic check_halt(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         mismatch_count++;
         $display("MISMATCH %s: expected halt=%0b actual halt=%0b", name, exp, act);
      end
   endtask

   // advance the model by one clock and check wb mid-cycle
   task automatic drive_cycle(input string name, input logic [`ILEN-1:0] ins,
                              input logic v, input logic f, input logic s);
      @(posedge clk);
      if (prev_stall) begin
         wb_exp.valid = 1'b0;
         wb_exp.wr_en = 1'b0;
         wb_exp.halt  = 1'b0;
      end else begin
         wb_exp = ex_exp;
         ex_exp = predict(prev_instr, prev_valid, prev_flush);
      end
      prev_instr = ins;
      prev_valid = v;
      prev_flush = f;
      prev_stall = s;
      instr       <= ins;
      instr_valid <= v;
      flush       <= f;
      stall       <= s;
      @(negedge clk);
      check_wb(name, wb_exp, wb);
      check_halt(name, wb_exp.halt, wb.halt);
      if (wb.halt) begin
         halt_seen = 1'b1;
      end
   endtask

   task automatic issue(input string name, input logic [`ILEN-1:0] ins);
      drive_cycle(name, ins, 1'b1, 1'b0, 1'b0);
   endtask

   task automatic idle_cycles(input string name, input int n);
      repeat (n) drive_cycle(name, '0, 1'b0, 1'b0, 1'b0);
   endtask

   // no shift op so double 16 times and mix in a low half
   task automatic load_random_word(input string name, input logic [4:0] rd);
      logic [15:0] hi;
      logic [15:0] lo;
      hi = 16'($random(seed));
      lo = 16'($random(seed));
      issue(name, i_type(LI, rd, 0, hi));
      repeat (16) issue(name, r_type(ADD, rd, rd, rd));
      issue(name, i_type(LI, 16, 0, lo));
      issue(name, r_type(XOR_OP, rd, rd, 16));
   endtask

   task automatic reset_and_load();
      logic [15:0] imms [8];
      imms = '{16'h0001, 16'h7fff, 16'h8000, 16'hffff, 16'h1234, 16'hff00, 16'h00ff, 16'ha5a5};
      idle_cycles("reset", 3);
      foreach (imms[n]) begin
         issue("load", i_type(LI, 5'(n + 1), 0, imms[n]));
      end
      idle_cycles("load", 2);
   endtask

   task automatic scalar_alu_ops();
      opcode_e    ops [7];
      opcode_e    op;
      logic [4:0] rd;
      logic [4:0] rs;
      logic [4:0] last_rd;
      ops = '{ADD, SUB, AND_OP, OR_OP, XOR_OP, SLT, ADDI};
      issue("alu_chain", r_type(ADD, 9, 1, 2));
      issue("alu_chain", r_type(SUB, 10, 9, 3));
      issue("alu_chain", r_type(SLT, 11, 10, 9));
      issue("alu_chain", i_type(ADDI, 9, 9, 16'hfffb));
      issue("alu_chain", r_type(XOR_OP, 12, 9, 11));
      last_rd = 5'd12;
      for (int n = 0; n < 48; n++) begin
         op = ops[{$random(seed)} % 7];
         rd = 5'(1 + {$random(seed)} % 31);
         // every other one reads the previous result
         rs = (n % 2) ? last_rd : 5'($random(seed));
         if (op == ADDI) begin
            issue("alu_random", i_type(op, rd, rs, 16'($random(seed))));
         end else begin
            issue("alu_random", r_type(op, rd, rs, 5'($random(seed))));
         end
         last_rd = rd;
      end
      idle_cycles("alu_random", 2);
   endtask

   task automatic simd_lane_ops();
      opcode_e ops [4];
      ops = '{PADDB, PSUBB, PADDUSB, PMAXUB};
      for (int w = 12; w < 16; w++) begin
         load_random_word("simd_load", 5'(w));
      end
      for (int k = 0; k < 4; k++) begin
         issue("simd_random", r_type(ops[k], 17, 12, 13));
         issue("simd_random", r_type(ops[k], 18, 14, 15));
         issue("simd_random", r_type(ops[k], 19, 17, 18));
      end
      // lanes 80/7f/00/00 against f0/c0/ff/ff
      issue("simd_edges", i_type(LI, 20, 0, 16'h7f80));
      issue("simd_edges", i_type(LI, 21, 0, 16'hc0f0));
      for (int k = 0; k < 4; k++) begin
         issue("simd_edges", r_type(ops[k], 22, 20, 21));
      end
      issue("simd_edges", r_type(PADDUSB, 23, 21, 21));
      idle_cycles("simd_edges", 2);
   endtask

   task automatic stall_delay();
      int lens [2];
      lens = '{1, 3};
      foreach (lens[n]) begin
         issue("stall", i_type(LI, 1, 0, 16'(16'h0abc + n)));
         repeat (lens[n]) drive_cycle("stall", r_type(ADD, 2, 1, 1), 1'b1, 1'b0, 1'b1);
         issue("stall", r_type(ADD, 2, 1, 1));
         issue("stall", r_type(SUB, 3, 2, 1));
      end
      idle_cycles("stall", 2);
   endtask

   task automatic flush_squash();
      issue("flush", i_type(LI, 5, 0, 16'h1234));
      drive_cycle("flush", i_type(LI, 5, 0, 16'h7777), 1'b1, 1'b1, 1'b0);
      issue("flush", r_type(ADD, 6, 5, 0));
      drive_cycle("flush", r_type(ADD, 5, 5, 5), 1'b1, 1'b1, 1'b0);
      drive_cycle("flush", i_type(LI, 5, 0, 16'h5555), 1'b0, 1'b0, 1'b0);
      idle_cycles("flush", 2);
      issue("flush", r_type(OR_OP, 7, 5, 5));
      idle_cycles("flush", 2);
   endtask

   task automatic halt_stop();
      drive_cycle("halt_flushed", r_type(HALT, 0, 0, 0), 1'b1, 1'b1, 1'b0);
      idle_cycles("halt_flushed", 2);
      issue("halt", r_type(HALT, 0, 0, 0));
      idle_cycles("halt", 2);
      if (!halt_seen) begin
         fail_count++;
         $display("halt: wb.halt was never raised two cycles after HALT issued");
      end
   endtask

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
         $display("errors: %0d mismatches, %0d other failures", mismatch_count,
                  fail_count + 1);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      instr          = '0;
      instr_valid    = 1'b0;
      stall          = 1'b0;
      flush          = 1'b0;
      rst_n          = 1'b0;
      seed           = 32'h5f83267d;
      mismatch_count = 0;
      fail_count     = 0;
      cycle_count    = 0;
      halt_seen      = 1'b0;
      ex_exp         = '0;
      wb_exp         = '0;
      prev_instr     = '0;
      prev_valid     = 1'b0;
      prev_flush     = 1'b0;
      prev_stall     = 1'b0;
      foreach (model_regs[i]) begin
         model_regs[i] = '0;
      end
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      // wb as left by reset itself
      @(negedge clk);
      check_wb("reset", wb_exp, wb);
      check_halt("reset", 1'b0, wb.halt);
      reset_and_load();
      scalar_alu_ops();
      simd_lane_ops();
      stall_delay();
      flush_squash();
      halt_stop();
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
      if (mismatch_count == 0 && fail_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- verilog/cpu_id_ex_top.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_id_ex_top import pipe_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [`ILEN-1:0] instr,
   input  logic             instr_valid,
   input  logic             stall,
   input  logic             flush,
   output wb_t              wb
);

   id_ex_t                       id_payload;
   id_ex_t                       ex_payload;
   wb_t                          ex_fwd;
   logic [`NUM_LANES-1:0][7:0]   lane_result;

   decode_stage decode_stage_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .flush       (flush),
      .wb          (wb),
      .ex_fwd      (ex_fwd),
      .id_payload  (id_payload)
   );

   id_ex_reg id_ex_reg_i (
      .clk   (clk),
      .rst_n (rst_n),
      .stall (stall),
      .d     (id_payload),
      .q     (ex_payload)
   );

   // one lane per byte, shared op select
   for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
      simd_byte_lane simd_byte_lane_i (
         .a  (ex_payload.rs_data[8*i +: 8]),
         .b  (ex_payload.rt_data[8*i +: 8]),
         .op (ex_payload.ctrl.simd_op),
         .y  (lane_result[i])
      );
   end

   exec_stage exec_stage_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .stall       (stall),
      .ex_payload  (ex_payload),
      .lane_result (lane_result),
      .ex_fwd      (ex_fwd),
      .wb          (wb)
   );

endmodule

//--- verilog/exec_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module exec_stage import isa_pkg::*, pipe_pkg::*; (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         stall,
   input  id_ex_t                       ex_payload,
   input  logic [`NUM_LANES-1:0][7:0]   lane_result,
   output wb_t                          ex_fwd,
   output wb_t                          wb
);

   logic [`XLEN-1:0] a;
   logic [`XLEN-1:0] b_sel;
   logic [`XLEN-1:0] b_op;
   logic [`XLEN-1:0] sum;
   logic [`XLEN-1:0] alu_y;
   logic [`XLEN-1:0] simd_y;
   logic             lt;

   assign a      = ex_payload.rs_data;
   assign b_sel  = ex_payload.ctrl.alu_src ? ex_payload.imm_value : ex_payload.rt_data;
   assign b_op   = ex_payload.ctrl.inv_b ? ~b_sel : b_sel;
   assign sum    = a + b_op + `XLEN'(ex_payload.ctrl.cin);
   assign simd_y = ex_payload.ctrl.simd_en ? lane_result : '0;

   // signs differ: a is less when negative
   assign lt = (a[`XLEN-1] ^ b_sel[`XLEN-1]) ? a[`XLEN-1] : sum[`XLEN-1];

   always_comb begin
      case (ex_payload.ctrl.alu_op)
         ALU_ADD:   alu_y = sum;
         ALU_AND:   alu_y = a & b_sel;
         ALU_OR:    alu_y = a | b_sel;
         ALU_XOR:   alu_y = a ^ b_sel;
         ALU_SLT:   alu_y = {{(`XLEN - 1){1'b0}}, lt};
         ALU_PASSB: alu_y = b_sel;
         default:   alu_y = '0;
      endcase
   end

   always_comb begin
      ex_fwd.valid = instr_opcode(ex_payload.instruction) != BUBBLE;
      ex_fwd.rd    = ex_payload.ctrl.rd;
      ex_fwd.wr_en = ex_payload.ctrl.wr_en;
      ex_fwd.halt  = ex_payload.ctrl.halt;
      ex_fwd.data  = (ex_payload.ctrl.wr_sel == WR_SEL_SIMD) ? simd_y : alu_y;
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         wb.rd   <= ex_fwd.rd;
         wb.data <= ex_fwd.data;
      end
      if (!rst_n || stall) begin
         wb.valid <= 1'b0;
         wb.wr_en <= 1'b0;
         wb.halt  <= 1'b0;
      end else begin
         wb.valid <= ex_fwd.valid;
         wb.wr_en <= ex_fwd.wr_en;
         wb.halt  <= ex_fwd.halt;
      end
   end

   a_wr_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
      wb.wr_en |-> wb.valid);

endmodule

//--- verilog/id_ex_reg.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module id_ex_reg import pipe_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   stall,
   input  id_ex_t d,
   output id_ex_t q
);

   // whole payload held while stalled
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         q <= ID_EX_BUBBLE;
      end else if (!stall) begin
         q <= d;
      end
   end

   a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      stall |=> $stable(q));

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [`ILEN-1:0] instr,
   input  logic             instr_valid,
   input  logic             flush,
   input  wb_t              wb,
   input  wb_t              ex_fwd,
   output id_ex_t           id_payload
);

   logic [`XLEN-1:0]   regs [`NUM_REGS];
   opcode_e            opcode;
   logic [`REG_AW-1:0] rs;
   logic [`REG_AW-1:0] rt;
   ctrl_t              ctrl;

   // newest value wins: execute, then writeback, then regfile
   function automatic logic [`XLEN-1:0] read_operand(
      input logic [`REG_AW-1:0] idx,
      input logic [`XLEN-1:0]   rf_val,
      input wb_t                fwd_ex,
      input wb_t                fwd_wb
   );
      logic [`XLEN-1:0] val;
      if (idx == '0) begin
         val = '0;
      end else if (fwd_ex.wr_en && fwd_ex.rd == idx) begin
         val = fwd_ex.data;
      end else if (fwd_wb.valid && fwd_wb.wr_en && fwd_wb.rd == idx) begin
         val = fwd_wb.data;
      end else begin
         val = rf_val;
      end
      return val;
   endfunction

   assign opcode = instr_opcode(instr);
   assign rs     = instr_rs(instr);
   assign rt     = instr_rt(instr);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid && wb.wr_en && wb.rd != '0) begin
         regs[wb.rd] <= wb.data;
      end
   end

   always_comb begin
      ctrl    = '0;
      ctrl.rd = instr_rd(instr);
      case (opcode)
         LI: begin
            ctrl.alu_op  = ALU_PASSB;
            ctrl.alu_src = 1'b1;
            ctrl.wr_en   = 1'b1;
         end
         ADD:    ctrl.wr_en = 1'b1;
         SUB: begin
            ctrl.inv_b = 1'b1;
            ctrl.cin   = 1'b1;
            ctrl.wr_en = 1'b1;
         end
         AND_OP: begin
            ctrl.alu_op = ALU_AND;
            ctrl.wr_en  = 1'b1;
         end
         OR_OP: begin
            ctrl.alu_op = ALU_OR;
            ctrl.wr_en  = 1'b1;
         end
         XOR_OP: begin
            ctrl.alu_op = ALU_XOR;
            ctrl.wr_en  = 1'b1;
         end
         // signed compare off a - b
         SLT: begin
            ctrl.alu_op = ALU_SLT;
            ctrl.inv_b  = 1'b1;
            ctrl.cin    = 1'b1;
            ctrl.wr_en  = 1'b1;
         end
         ADDI: begin
            ctrl.alu_src = 1'b1;
            ctrl.wr_en   = 1'b1;
         end
         PADDB, PSUBB, PADDUSB, PMAXUB: begin
            ctrl.simd_en = 1'b1;
            ctrl.wr_sel  = WR_SEL_SIMD;
            ctrl.wr_en   = 1'b1;
            case (opcode)
               PSUBB:   ctrl.simd_op = SIMD_SUB;
               PADDUSB: ctrl.simd_op = SIMD_ADDUS;
               PMAXUB:  ctrl.simd_op = SIMD_MAXU;
               default: ctrl.simd_op = SIMD_ADD;
            endcase
         end
         HALT:    ctrl.halt = 1'b1;
         default: ctrl.wr_sel = WR_SEL_ALU;
      endcase
   end

   always_comb begin
      if (flush || !instr_valid) begin
         id_payload = ID_EX_BUBBLE;
      end else begin
         id_payload.ctrl        = ctrl;
         id_payload.rs_data     = read_operand(rs, regs[rs], ex_fwd, wb);
         id_payload.rt_data     = read_operand(rt, regs[rt], ex_fwd, wb);
         id_payload.imm_value   = instr_imm(instr);
         id_payload.instruction = instr;
      end
   end

   a_r0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (wb.valid && wb.wr_en && wb.rd == '0) |=> (regs[0] == '0));

endmodule

//--- verilog/simd_byte_lane.sv
`timescale 1ns/1ps

module simd_byte_lane import isa_pkg::*; (
   input  logic [7:0] a,
   input  logic [7:0] b,
   input  simd_op_e   op,
   output logic [7:0] y
);

   logic [8:0] sum9;

   // carry out marks unsigned overflow
   assign sum9 = {1'b0, a} + {1'b0, b};

   always_comb begin
      case (op)
         SIMD_ADD:   y = sum9[7:0];
         SIMD_SUB:   y = a - b;
         SIMD_ADDUS: y = sum9[8] ? 8'hff : sum9[7:0];
         SIMD_MAXU:  y = (a > b) ? a : b;
         default:    y = '0;
      endcase
   end

endmodule

//--- verilog/pipe_pkg.sv
`include "cpu_defines.svh"

package pipe_pkg;

   import isa_pkg::*;

   // wr_sel encodings
   localparam logic [1:0] WR_SEL_ALU  = 2'd0;
   localparam logic [1:0] WR_SEL_SIMD = 2'd1;

   typedef struct packed {
      alu_op_e            alu_op;
      logic               inv_b;
      logic               cin;
      logic               alu_src;
      logic               simd_en;
      simd_op_e           simd_op;
      logic [1:0]         wr_sel;
      logic [`REG_AW-1:0] rd;
      logic               wr_en;
      logic               halt;
   } ctrl_t;

   typedef struct packed {
      ctrl_t             ctrl;
      logic [`XLEN-1:0]  rs_data;
      logic [`XLEN-1:0]  rt_data;
      logic [`XLEN-1:0]  imm_value;
      logic [`ILEN-1:0]  instruction;
   } id_ex_t;

   typedef struct packed {
      logic               valid;
      logic [`REG_AW-1:0] rd;
      logic               wr_en;
      logic [`XLEN-1:0]   data;
      logic               halt;
   } wb_t;

   // flush filler, no side effects
   localparam id_ex_t ID_EX_BUBBLE = '{
      ctrl:        '0,
      rs_data:     '0,
      rt_data:     '0,
      imm_value:   '0,
      instruction: {BUBBLE, {(`OP_LO){1'b0}}}
   };

endpackage

//--- verilog/isa_pkg.sv
`include "cpu_defines.svh"

package isa_pkg;

   typedef enum logic [5:0] {
      NOP     = 6'd0,
      BUBBLE  = 6'd1,
      LI      = 6'd2,
      ADD     = 6'd3,
      SUB     = 6'd4,
      AND_OP  = 6'd5,
      OR_OP   = 6'd6,
      XOR_OP  = 6'd7,
      SLT     = 6'd8,
      ADDI    = 6'd9,
      PADDB   = 6'd16,
      PSUBB   = 6'd17,
      PADDUSB = 6'd18,
      PMAXUB  = 6'd19,
      HALT    = 6'd63
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD   = 4'd0,
      ALU_AND   = 4'd1,
      ALU_OR    = 4'd2,
      ALU_XOR   = 4'd3,
      ALU_SLT   = 4'd4,
      ALU_PASSB = 4'd5
   } alu_op_e;

   // add and sub wrap, addus clamps at 255
   typedef enum logic [3:0] {
      SIMD_ADD   = 4'd0,
      SIMD_SUB   = 4'd1,
      SIMD_ADDUS = 4'd2,
      SIMD_MAXU  = 4'd3
   } simd_op_e;

   function automatic opcode_e instr_opcode(input logic [`ILEN-1:0] instr);
      return opcode_e'(instr[`OP_HI:`OP_LO]);
   endfunction

   function automatic logic [`REG_AW-1:0] instr_rd(input logic [`ILEN-1:0] instr);
      return instr[`RD_HI:`RD_LO];
   endfunction

   function automatic logic [`REG_AW-1:0] instr_rs(input logic [`ILEN-1:0] instr);
      return instr[`RS_HI:`RS_LO];
   endfunction

   function automatic logic [`REG_AW-1:0] instr_rt(input logic [`ILEN-1:0] instr);
      return instr[`RT_HI:`RT_LO];
   endfunction

   // imm16 is sign-extended to the data width
   function automatic logic [`XLEN-1:0] instr_imm(input logic [`ILEN-1:0] instr);
      return {{(`XLEN - 16){instr[`IMM_HI]}}, instr[`IMM_HI:`IMM_LO]};
   endfunction

endpackage

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath sizes
`define XLEN      32
`define ILEN      32
`define NUM_REGS  32
`define REG_AW    5
`define NUM_LANES (`XLEN / 8)

// instruction field positions
`define OP_HI     31
`define OP_LO     26
`define RD_HI     25
`define RD_LO     21
`define RS_HI     20
`define RS_LO     16
`define RT_HI     15
`define RT_LO     11
`define IMM_HI    15
`define IMM_LO    0

`endif
